// File: hdl/pe_pkg.sv
package pe_pkg;

    //////////////////////////////////////////////////////////////////////
    // Bus geometry
    //////////////////////////////////////////////////////////////////////

    localparam int DATA_W      = 32;
    localparam int ADDR_W      = 32;
    localparam int BE_W        = 4;
    localparam int DMEM_ADDR_W = 24;
    localparam int REGION_W    = 8;

    // Top address byte of each mapped region
    typedef enum logic [REGION_W-1:0] {
        REGION_DMEM = 8'h01,
        REGION_RTC  = 8'h02,
        REGION_PLIC = 8'h04
    } region_t;

    //////////////////////////////////////////////////////////////////////
    // Peripheral register maps (word offsets)
    //////////////////////////////////////////////////////////////////////

    localparam int                  RTC_OFS_W    = 2;
    localparam logic [RTC_OFS_W-1:0] RTC_MTIME_LO = 2'd0;
    localparam logic [RTC_OFS_W-1:0] RTC_MTIME_HI = 2'd1;
    localparam logic [RTC_OFS_W-1:0] RTC_CMP_LO   = 2'd2;
    localparam logic [RTC_OFS_W-1:0] RTC_CMP_HI   = 2'd3;
    localparam int                  MTIME_W      = 64;

    localparam int                   PLIC_OFS_W   = 2;
    localparam logic [PLIC_OFS_W-1:0] PLIC_ENABLE  = 2'd0;
    localparam logic [PLIC_OFS_W-1:0] PLIC_PENDING = 2'd1;
    localparam logic [PLIC_OFS_W-1:0] PLIC_CLAIM   = 2'd2;
    localparam int                   PLIC_SOURCES = 4;
    localparam int                   PLIC_ID_W    = 3;

endpackage

// File: hdl/pe_bus_decoder.sv
`timescale 1ns/1ps

module pe_bus_decoder (
    input  logic                               clk_i,
    input  logic                               rst_ni,

    // Wishbone classic slave
    input  logic                               wb_cyc_i,
    input  logic                               wb_stb_i,
    input  logic                               wb_we_i,
    input  logic [pe_pkg::BE_W-1:0]            wb_sel_i,
    input  logic [pe_pkg::ADDR_W-1:0]          wb_adr_i,
    input  logic [pe_pkg::DATA_W-1:0]          wb_dat_i,
    output logic [pe_pkg::DATA_W-1:0]          wb_dat_o,
    output logic                               wb_ack_o,

    // External data memory
    output logic                               dmem_en_o,
    output logic [pe_pkg::BE_W-1:0]            dmem_we_o,
    output logic [pe_pkg::DMEM_ADDR_W-1:0]     dmem_addr_o,
    output logic [pe_pkg::DATA_W-1:0]          dmem_data_o,
    input  logic [pe_pkg::DATA_W-1:0]          dmem_data_i,

    // Peripherals
    output logic                               rtc_en_o,
    output logic [pe_pkg::BE_W-1:0]            rtc_we_o,
    output logic [pe_pkg::RTC_OFS_W-1:0]       rtc_ofs_o,
    input  logic [pe_pkg::DATA_W-1:0]          rtc_data_i,
    output logic                               plic_en_o,
    output logic [pe_pkg::BE_W-1:0]            plic_we_o,
    output logic [pe_pkg::PLIC_OFS_W-1:0]      plic_ofs_o,
    input  logic [pe_pkg::DATA_W-1:0]          plic_data_i,
    output logic [pe_pkg::DATA_W-1:0]          periph_wdata_o
);

    import pe_pkg::*;

    logic            req;
    logic            ack_q;
    region_t         region;
    region_t         sel_q;
    logic [BE_W-1:0] be;

    //////////////////////////////////////////////////////////////////////
    // Request decode
    //////////////////////////////////////////////////////////////////////

    // New access only while no ack is pending
    assign req    = wb_cyc_i && wb_stb_i && !ack_q;
    assign region = region_t'(wb_adr_i[ADDR_W-1 -: REGION_W]);
    assign be     = wb_we_i ? wb_sel_i : '0;

    assign dmem_en_o   = req && (region == REGION_DMEM);
    assign dmem_we_o   = be;
    assign dmem_addr_o = wb_adr_i[DMEM_ADDR_W-1:0];
    assign dmem_data_o = wb_dat_i;

    assign rtc_en_o   = req && (region == REGION_RTC);
    assign rtc_we_o   = be;
    assign rtc_ofs_o  = wb_adr_i[2 +: RTC_OFS_W];
    assign plic_en_o  = req && (region == REGION_PLIC);
    assign plic_we_o  = be;
    assign plic_ofs_o = wb_adr_i[2 +: PLIC_OFS_W];

    assign periph_wdata_o = wb_dat_i;

    //////////////////////////////////////////////////////////////////////
    // Ack and read mux
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ack_q <= 1'b0;
            sel_q <= region_t'('0);
        end else begin
            ack_q <= req;
            if (req) begin
                sel_q <= region;
            end
        end
    end

    assign wb_ack_o = ack_q;

    // Unmapped regions read as zero
    always_comb begin
        wb_dat_o = '0;
        if (ack_q) begin
            case (sel_q)
                REGION_DMEM: wb_dat_o = dmem_data_i;
                REGION_RTC:  wb_dat_o = rtc_data_i;
                REGION_PLIC: wb_dat_o = plic_data_i;
                default:     wb_dat_o = '0;
            endcase
        end
    end

endmodule

// File: hdl/pe_rtc.sv
`timescale 1ns/1ps

module pe_rtc (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          en_i,
    input  logic [pe_pkg::BE_W-1:0]       we_i,
    input  logic [pe_pkg::RTC_OFS_W-1:0]  ofs_i,
    input  logic [pe_pkg::DATA_W-1:0]     data_i,
    output logic [pe_pkg::DATA_W-1:0]     data_o,
    output logic                          mti_o
);

    import pe_pkg::*;

    logic [MTIME_W-1:0] mtime_q;
    logic [MTIME_W-1:0] mtime_d;
    logic [MTIME_W-1:0] mtimecmp_q;
    logic [MTIME_W-1:0] mtimecmp_d;
    logic [DATA_W-1:0]  rd_word;

    // Replace the byte lanes selected by be
    function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_w,
                                                      input logic [DATA_W-1:0] new_w,
                                                      input logic [BE_W-1:0]   be);
        logic [DATA_W-1:0] res;
        res = old_w;
        for (int b = 0; b < BE_W; b++) begin
            if (be[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    // Counter keeps running and written bytes override it
    always_comb begin
        mtime_d    = mtime_q + 1'b1;
        mtimecmp_d = mtimecmp_q;
        if (en_i) begin
            case (ofs_i)
                RTC_MTIME_LO: mtime_d[31:0]     = merge_bytes(mtime_d[31:0], data_i, we_i);
                RTC_MTIME_HI: mtime_d[63:32]    = merge_bytes(mtime_d[63:32], data_i, we_i);
                RTC_CMP_LO:   mtimecmp_d[31:0]  = merge_bytes(mtimecmp_q[31:0], data_i, we_i);
                RTC_CMP_HI:   mtimecmp_d[63:32] = merge_bytes(mtimecmp_q[63:32], data_i, we_i);
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mtime_q    <= '0;
            mtimecmp_q <= '1;
        end else begin
            mtime_q    <= mtime_d;
            mtimecmp_q <= mtimecmp_d;
        end
    end

    always_comb begin
        case (ofs_i)
            RTC_MTIME_LO: rd_word = mtime_q[31:0];
            RTC_MTIME_HI: rd_word = mtime_q[63:32];
            RTC_CMP_LO:   rd_word = mtimecmp_q[31:0];
            default:      rd_word = mtimecmp_q[63:32];
        endcase
    end

    // Read word for the ack cycle
    always_ff @(posedge clk_i) begin
        if (en_i) begin
            data_o <= rd_word;
        end
    end

    assign mti_o = (mtime_q >= mtimecmp_q);

endmodule

// File: hdl/pe_plic.sv
`timescale 1ns/1ps

module pe_plic (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    input  logic                            en_i,
    input  logic [pe_pkg::BE_W-1:0]         we_i,
    input  logic [pe_pkg::PLIC_OFS_W-1:0]   ofs_i,
    input  logic [pe_pkg::DATA_W-1:0]       data_i,
    output logic [pe_pkg::DATA_W-1:0]       data_o,
    input  logic [pe_pkg::PLIC_SOURCES-1:0] irq_i,
    output logic                            meip_o
);

    import pe_pkg::*;

    logic [PLIC_SOURCES-1:0] irq_q;
    logic [PLIC_SOURCES-1:0] rise;
    logic [PLIC_SOURCES-1:0] pending_q;
    logic [PLIC_SOURCES-1:0] enable_q;
    logic [PLIC_SOURCES-1:0] active;
    logic [PLIC_SOURCES-1:0] claim_mask;
    logic [PLIC_ID_W-1:0]    claim_id;
    logic                    claim_rd;
    logic                    enable_wr;
    logic [DATA_W-1:0]       rd_word;

    //////////////////////////////////////////////////////////////////////
    // Edge capture and claim
    //////////////////////////////////////////////////////////////////////

    assign rise   = irq_i & ~irq_q;
    assign active = pending_q & enable_q;

    // Lowest numbered active source wins with a one-based id
    always_comb begin
        claim_id   = '0;
        claim_mask = '0;
        for (int i = PLIC_SOURCES - 1; i >= 0; i--) begin
            if (active[i]) begin
                claim_id       = PLIC_ID_W'(i + 1);
                claim_mask     = '0;
                claim_mask[i]  = 1'b1;
            end
        end
    end

    // Only a read of the claim register takes the interrupt
    assign claim_rd  = en_i && (we_i == '0) && (ofs_i == PLIC_CLAIM);
    assign enable_wr = en_i && we_i[0] && (ofs_i == PLIC_ENABLE);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            irq_q     <= '0;
            pending_q <= '0;
            enable_q  <= '0;
        end else begin
            irq_q <= irq_i;
            // A fresh edge is never lost to a claim
            if (claim_rd) begin
                pending_q <= (pending_q & ~claim_mask) | rise;
            end else begin
                pending_q <= pending_q | rise;
            end
            if (enable_wr) begin
                enable_q <= data_i[PLIC_SOURCES-1:0];
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Register read
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (ofs_i)
            PLIC_ENABLE:  rd_word = DATA_W'(enable_q);
            PLIC_PENDING: rd_word = DATA_W'(pending_q);
            PLIC_CLAIM:   rd_word = DATA_W'(claim_id);
            default:      rd_word = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (en_i) begin
            data_o <= rd_word;
        end
    end

    assign meip_o = |active;

endmodule

// File: hdl/pe_periph_bus.sv
`timescale 1ns/1ps

module pe_periph_bus (
    input  logic                            clk_i,
    input  logic                            rst_ni,

    // Wishbone classic slave
    input  logic                            wb_cyc_i,
    input  logic                            wb_stb_i,
    input  logic                            wb_we_i,
    input  logic [pe_pkg::BE_W-1:0]         wb_sel_i,
    input  logic [pe_pkg::ADDR_W-1:0]       wb_adr_i,
    input  logic [pe_pkg::DATA_W-1:0]       wb_dat_i,
    output logic [pe_pkg::DATA_W-1:0]       wb_dat_o,
    output logic                            wb_ack_o,

    // Data memory
    output logic                            dmem_en_o,
    output logic [pe_pkg::BE_W-1:0]         dmem_we_o,
    output logic [pe_pkg::DMEM_ADDR_W-1:0]  dmem_addr_o,
    output logic [pe_pkg::DATA_W-1:0]       dmem_data_o,
    input  logic [pe_pkg::DATA_W-1:0]       dmem_data_i,

    // Interrupts
    input  logic [pe_pkg::PLIC_SOURCES-1:0] irq_i,
    output logic                            mti_o,
    output logic                            meip_o
);

    import pe_pkg::*;

    logic                  rtc_en;
    logic [BE_W-1:0]       rtc_we;
    logic [RTC_OFS_W-1:0]  rtc_ofs;
    logic [DATA_W-1:0]     rtc_rdata;
    logic                  plic_en;
    logic [BE_W-1:0]       plic_we;
    logic [PLIC_OFS_W-1:0] plic_ofs;
    logic [DATA_W-1:0]     plic_rdata;
    logic [DATA_W-1:0]     periph_wdata;

    pe_bus_decoder u_decoder (
        .clk_i          (clk_i       ),
        .rst_ni         (rst_ni      ),
        .wb_cyc_i       (wb_cyc_i    ),
        .wb_stb_i       (wb_stb_i    ),
        .wb_we_i        (wb_we_i     ),
        .wb_sel_i       (wb_sel_i    ),
        .wb_adr_i       (wb_adr_i    ),
        .wb_dat_i       (wb_dat_i    ),
        .wb_dat_o       (wb_dat_o    ),
        .wb_ack_o       (wb_ack_o    ),
        .dmem_en_o      (dmem_en_o   ),
        .dmem_we_o      (dmem_we_o   ),
        .dmem_addr_o    (dmem_addr_o ),
        .dmem_data_o    (dmem_data_o ),
        .dmem_data_i    (dmem_data_i ),
        .rtc_en_o       (rtc_en      ),
        .rtc_we_o       (rtc_we      ),
        .rtc_ofs_o      (rtc_ofs     ),
        .rtc_data_i     (rtc_rdata   ),
        .plic_en_o      (plic_en     ),
        .plic_we_o      (plic_we     ),
        .plic_ofs_o     (plic_ofs    ),
        .plic_data_i    (plic_rdata  ),
        .periph_wdata_o (periph_wdata)
    );

    pe_rtc u_rtc (
        .clk_i  (clk_i       ),
        .rst_ni (rst_ni      ),
        .en_i   (rtc_en      ),
        .we_i   (rtc_we      ),
        .ofs_i  (rtc_ofs     ),
        .data_i (periph_wdata),
        .data_o (rtc_rdata   ),
        .mti_o  (mti_o       )
    );

    pe_plic u_plic (
        .clk_i  (clk_i       ),
        .rst_ni (rst_ni      ),
        .en_i   (plic_en     ),
        .we_i   (plic_we     ),
        .ofs_i  (plic_ofs    ),
        .data_i (periph_wdata),
        .data_o (plic_rdata  ),
        .irq_i  (irq_i       ),
        .meip_o (meip_o      )
    );

endmodule

// File: verification/tb_pe_periph_bus.sv
`timescale 1ns/1ps

module tb_pe_periph_bus;

    import pe_pkg::*;

    localparam int CLK_HALF     = 50;
    localparam int DRIVE_DLY    = 1;
    localparam int DMEM_OPS     = 100;
    localparam int UNMAPPED_OPS = 30;
    localparam int CMP_OPS      = 10;
    localparam int PLIC_ROUNDS  = 30;
    // About 500 accesses of 3 cycles each and the limit doubled
    localparam int ACCESS_BUDGET  = 500;
    localparam int TIMEOUT_CYCLES = 2 * 3 * ACCESS_BUDGET;

    logic                    clk_i;
    logic                    rst_ni;
    logic                    wb_cyc_i;
    logic                    wb_stb_i;
    logic                    wb_we_i;
    logic [BE_W-1:0]         wb_sel_i;
    logic [ADDR_W-1:0]       wb_adr_i;
    logic [DATA_W-1:0]       wb_dat_i;
    logic [DATA_W-1:0]       wb_dat_o;
    logic                    wb_ack_o;
    logic                    dmem_en_o;
    logic [BE_W-1:0]         dmem_we_o;
    logic [DMEM_ADDR_W-1:0]  dmem_addr_o;
    logic [DATA_W-1:0]       dmem_data_o;
    logic [DATA_W-1:0]       dmem_data_i;
    logic [PLIC_SOURCES-1:0] irq_i;
    logic                    mti_o;
    logic                    meip_o;

    logic [31:0] mem [256];
    logic [31:0] exp_mem [256];
    logic [7:0]  mem_idx;
    logic [31:0] mem_rd;
    logic [31:0] lcg_state;
    int          errors;
    int          checks;
    int          test_start_errors;
    int          cycles = 0;

    pe_periph_bus u_pe_periph_bus (.*);

    always #CLK_HALF clk_i = ~clk_i;

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] rand32();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state ^ (lcg_state >> 16);
    endfunction

    // Byte lane select expanded to a bit mask
    function automatic logic [31:0] lane_mask(input logic [3:0] sel);
        return {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
    endfunction

    function automatic logic [31:0] lowest_id(input logic [3:0] act);
        logic [31:0] id;
        id = 0;
        for (int i = 0; i < 4; i++) begin
            if (act[i] && id == 0) begin
                id = i + 1;
            end
        end
        return id;
    endfunction

    function automatic logic [31:0] reg_adr(input logic [7:0] region, input logic [1:0] ofs);
        return {region, 20'h0, ofs, 2'b00};
    endfunction

    task automatic check(input string sig, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s: got 0x%0h, expected 0x%0h", sig, got, exp);
        end
    endtask

    task automatic end_test(input string name);
        $display("%s: done, %0d errors", name, errors - test_start_errors);
        test_start_errors = errors;
    endtask

    // One Wishbone classic access from request through the idle cycle
    task automatic bus_access(input logic we, input logic [3:0] sel, input logic [31:0] adr,
                              input logic [31:0] wdat, output logic [31:0] rdat);
        logic dmem_hit;
        dmem_hit = (adr[31:24] == 8'h01);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_sel_i = sel;
        wb_adr_i = adr;
        wb_dat_i = wdat;
        @(negedge clk_i);
        check("wb_ack_o", wb_ack_o, 1'b0);
        check("dmem_en_o", dmem_en_o, dmem_hit);
        if (dmem_hit) begin
            check("dmem_addr_o", dmem_addr_o, adr[23:0]);
            check("dmem_we_o", dmem_we_o, we ? sel : 4'h0);
            if (we) begin
                check("dmem_data_o", dmem_data_o, wdat);
            end
        end
        // Ack cycle
        @(negedge clk_i);
        check("wb_ack_o", wb_ack_o, 1'b1);
        check("dmem_en_o", dmem_en_o, 1'b0);
        rdat = wb_dat_o;
        @(posedge clk_i);
        #DRIVE_DLY;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        @(negedge clk_i);
        check("wb_ack_o", wb_ack_o, 1'b0);
        check("dmem_en_o", dmem_en_o, 1'b0);
        @(posedge clk_i);
        #DRIVE_DLY;
    endtask

    task automatic bus_read(input logic [31:0] adr, output logic [31:0] rdat);
        bus_access(1'b0, 4'hf, adr, 32'h0, rdat);
    endtask

    task automatic bus_write(input logic [3:0] sel, input logic [31:0] adr,
                             input logic [31:0] wdat);
        logic [31:0] unused;
        bus_access(1'b1, sel, adr, wdat, unused);
    endtask

    //////////////////////////////////////////////////////////////////////
    // External data memory and timeout
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk_i) begin
        if (dmem_en_o) begin
            mem_idx = dmem_addr_o[9:2];
            mem_rd  = mem[mem_idx];
            mem[mem_idx] = (mem_rd & ~lane_mask(dmem_we_o)) |
                           (dmem_data_o & lane_mask(dmem_we_o));
            #DRIVE_DLY;
            dmem_data_i = mem_rd;
        end
    end

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] r;
        logic [31:0] adr;
        logic [31:0] rdat;
        logic [31:0] prev;
        logic [31:0] lo;
        logic [31:0] hi;
        logic [63:0] t;
        logic [7:0]  region;
        logic [3:0]  pend_m;
        logic [3:0]  en_m;
        logic [31:0] exp_id;

        lcg_state = 32'd60595;
        errors = 0;
        checks = 0;
        test_start_errors = 0;
        clk_i = 1'b0;
        rst_ni = 1'b0;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i = 1'b0;
        wb_sel_i = '0;
        wb_adr_i = '0;
        wb_dat_i = '0;
        dmem_data_i = '0;
        irq_i = '0;
        for (int i = 0; i < 256; i++) begin
            mem[i]     = 32'h9e37_79b9 * 32'(i + 1);
            exp_mem[i] = 32'h9e37_79b9 * 32'(i + 1);
        end

        // Reset held over four rising edges
        repeat (4) begin
            @(posedge clk_i);
            #DRIVE_DLY;
            check("wb_ack_o", wb_ack_o, 1'b0);
            check("dmem_en_o", dmem_en_o, 1'b0);
            check("mti_o", mti_o, 1'b0);
            check("meip_o", meip_o, 1'b0);
        end
        rst_ni = 1'b1;
        @(negedge clk_i);
        check("wb_ack_o", wb_ack_o, 1'b0);
        check("dmem_en_o", dmem_en_o, 1'b0);
        check("mti_o", mti_o, 1'b0);
        check("meip_o", meip_o, 1'b0);
        @(posedge clk_i);
        #DRIVE_DLY;
        end_test("reset");

        // Data memory with random writes and reads
        for (int i = 0; i < DMEM_OPS; i++) begin
            r = rand32();
            adr = {8'h01, r[23:2], 2'b00};
            r = rand32();
            bus_write(r[3:0], adr, rand32());
            exp_mem[adr[9:2]] = (exp_mem[adr[9:2]] & ~lane_mask(r[3:0])) |
                                (wb_dat_i & lane_mask(r[3:0]));
            // Half the reads hit the word just written
            if (r[31]) begin
                r = rand32();
                adr = {8'h01, r[23:2], 2'b00};
            end
            bus_read(adr, rdat);
            check("wb_dat_o", rdat, exp_mem[adr[9:2]]);
        end
        end_test("dmem");

        // Unmapped regions
        for (int i = 0; i < UNMAPPED_OPS; i++) begin
            r = rand32();
            region = r[31:24];
            if (region == 8'h01 || region == 8'h02 || region == 8'h04) begin
                region = region ^ 8'h80;
            end
            adr = {region, r[23:2], 2'b00};
            bus_write(4'hf, adr, rand32());
            bus_read(adr, rdat);
            check("wb_dat_o", rdat, 32'h0);
            bus_read({8'h01, adr[23:0]}, rdat);
            check("wb_dat_o", rdat, exp_mem[adr[9:2]]);
        end
        end_test("unmapped");

        // RTC
        bus_read(reg_adr(REGION_RTC, RTC_MTIME_LO), prev);
        for (int i = 0; i < CMP_OPS; i++) begin
            bus_read(reg_adr(REGION_RTC, RTC_MTIME_LO), rdat);
            check("mtime_lo increasing", rdat > prev, 1'b1);
            prev = rdat;
        end
        for (int i = 0; i < CMP_OPS; i++) begin
            lo = rand32();
            hi = rand32();
            bus_write(4'hf, reg_adr(REGION_RTC, RTC_CMP_LO), lo);
            bus_write(4'hf, reg_adr(REGION_RTC, RTC_CMP_HI), hi);
            bus_read(reg_adr(REGION_RTC, RTC_CMP_LO), rdat);
            check("mtimecmp_lo", rdat, lo);
            bus_read(reg_adr(REGION_RTC, RTC_CMP_HI), rdat);
            check("mtimecmp_hi", rdat, hi);
        end
        bus_read(reg_adr(REGION_RTC, RTC_MTIME_LO), lo);
        bus_read(reg_adr(REGION_RTC, RTC_MTIME_HI), hi);
        t = {hi, lo} + 64'd1001;
        bus_write(4'hf, reg_adr(REGION_RTC, RTC_CMP_HI), t[63:32]);
        bus_write(4'hf, reg_adr(REGION_RTC, RTC_CMP_LO), t[31:0]);
        @(negedge clk_i);
        check("mti_o", mti_o, 1'b0);
        @(posedge clk_i);
        #DRIVE_DLY;
        bus_read(reg_adr(REGION_RTC, RTC_MTIME_LO), lo);
        bus_read(reg_adr(REGION_RTC, RTC_MTIME_HI), hi);
        check("mti_o", mti_o, 1'b0);
        bus_write(4'hf, reg_adr(REGION_RTC, RTC_CMP_HI), hi);
        bus_write(4'hf, reg_adr(REGION_RTC, RTC_CMP_LO), lo);
        // Two cycles past the ack of the last write
        @(negedge clk_i);
        check("mti_o", mti_o, 1'b1);
        @(posedge clk_i);
        #DRIVE_DLY;
        end_test("rtc");

        // PLIC
        pend_m = '0;
        en_m   = '0;
        for (int i = 0; i < PLIC_ROUNDS; i++) begin
            r = rand32();
            irq_i = r[3:0];
            @(posedge clk_i);
            #DRIVE_DLY;
            irq_i = '0;
            pend_m = pend_m | r[3:0];
            if (r[8] || i == 0) begin
                adr = rand32();
                bus_write(r[7:4] | 4'(i == 0), reg_adr(REGION_PLIC, PLIC_ENABLE), adr);
                if (r[4] || i == 0) begin
                    en_m = adr[3:0];
                end
            end
            @(negedge clk_i);
            check("meip_o", meip_o, |(pend_m & en_m));
            @(posedge clk_i);
            #DRIVE_DLY;
            bus_read(reg_adr(REGION_PLIC, PLIC_PENDING), rdat);
            check("pending", rdat, {28'h0, pend_m});
            bus_read(reg_adr(REGION_PLIC, PLIC_CLAIM), rdat);
            exp_id = lowest_id(pend_m & en_m);
            check("claim", rdat, exp_id);
            if (exp_id != 0) begin
                pend_m[exp_id-1] = 1'b0;
            end
            check("meip_o", meip_o, |(pend_m & en_m));
        end
        end_test("plic");

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: files.f
hdl/pe_pkg.sv
hdl/pe_bus_decoder.sv
hdl/pe_rtc.sv
hdl/pe_plic.sv
hdl/pe_periph_bus.sv
verification/tb_pe_periph_bus.sv

// File: Makefile
TOP := tb_pe_periph_bus

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -f files.f --top-module $(TOP)

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Testbench passed$$"

clean:
	rm -rf obj_dir
